//--- rtl/tcp_defs.svh
`ifndef TCP_DEFS_SVH
`define TCP_DEFS_SVH

// number of connection slots
`define CONN_NUM 2

// slot index width, must cover CONN_NUM
`define SLOT_W 1

// tcp header field widths
`define PORT_W 16
`define SEQ_W 32

// cycles allowed for a connect or disconnect sequence
// small value so the timeout shows up quickly in simulation
`define CONN_TIMEOUT 64

`endif

//--- rtl/tcp_pkg.sv
`include "tcp_defs.svh"

package tcp_pkg;

  typedef logic [`PORT_W-1:0] port_t;
  typedef logic [`SEQ_W-1:0]  seq_t;  // sequence or acknowledge number
  typedef logic [`SLOT_W-1:0] slot_t;

  // same bit order as the tcp header
  typedef struct packed {
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flags_t;

  typedef struct packed {
    port_t      src_port;
    port_t      dst_port;
    seq_t       seq;
    seq_t       ack;
    tcp_flags_t flags;
  } tcp_seg_t;

  typedef enum logic [2:0] {
    evt_none,
    evt_syn,
    evt_syn_ack,
    evt_ack,
    evt_fin,
    evt_rst
  } rx_evt_e;

  typedef struct packed {
    rx_evt_e kind;
    seq_t    seq;
    seq_t    ack;
  } rx_evt_t;

  typedef struct packed {
    logic  listen;
    logic  connect;
    port_t loc_port;
    port_t rem_port; // peer port, also used when listening
    seq_t  isn;      // initial sequence number
  } conn_ctl_t;

  typedef struct packed {
    port_t loc_port;
    port_t rem_port;
    logic  bound; // rem_port is valid
    logic  open;  // listening or connecting
  } conn_key_t;

  typedef enum logic [2:0] {
    tcp_closed,
    tcp_listening,
    tcp_connecting,
    tcp_connected,
    tcp_disconnecting
  } conn_status_e;

  typedef enum logic [3:0] {
    st_closed,
    st_listen,
    st_syn_sent,
    st_ack_sent,
    st_syn_ack_sent,
    st_established,
    st_flush,
    st_fin_wait,
    st_close_ack,
    st_send_fin,
    st_last_wait,
    st_last_ack
  } conn_state_e;

endpackage

//--- rtl/tcp_seg_dispatch.sv
`include "tcp_defs.svh"

module tcp_seg_dispatch (
  input  logic               clk,
  input  logic               rst_rec,
  input  logic               rx_val,
  input  tcp_pkg::tcp_seg_t  rx_seg,
  input  tcp_pkg::conn_key_t keys [`CONN_NUM],
  output tcp_pkg::rx_evt_t   evt  [`CONN_NUM]
);
  import tcp_pkg::*;

  rx_evt_e kind;
  logic    hit;
  slot_t   slot_sel;

  // flag priority: rst, syn-ack, syn, fin, ack
  function automatic rx_evt_e seg_kind(input tcp_flags_t f);
    if (f.rst) return evt_rst;
    if (f.syn && f.ack) return evt_syn_ack;
    if (f.syn) return evt_syn;
    if (f.fin) return evt_fin;
    if (f.ack) return evt_ack;
    return evt_none;
  endfunction

  assign kind = seg_kind(rx_seg.flags);

  //////////////////////////////
  // slot lookup
  // loops run downwards so the lowest matching slot wins
  always_comb begin
    hit      = 1'b0;
    slot_sel = '0;
    // listening or connecting slot without a peer yet
    for (int i = `CONN_NUM - 1; i >= 0; i--) begin
      if (keys[i].open && !keys[i].bound && keys[i].loc_port == rx_seg.dst_port) begin
        hit      = 1'b1;
        slot_sel = slot_t'(i);
      end
    end
    // exact port pair match overrides the above
    for (int i = `CONN_NUM - 1; i >= 0; i--) begin
      if (keys[i].bound && keys[i].loc_port == rx_seg.dst_port &&
          keys[i].rem_port == rx_seg.src_port) begin
        hit      = 1'b1;
        slot_sel = slot_t'(i);
      end
    end
  end

  //////////////////////////////
  // event register
  always_ff @(posedge clk) begin
    for (int i = 0; i < `CONN_NUM; i++) begin
      evt[i].seq <= rx_seg.seq;
      evt[i].ack <= rx_seg.ack;
      if (rst_rec)
        evt[i].kind <= evt_none;
      else if (rx_val && hit && slot_sel == slot_t'(i))
        evt[i].kind <= kind; // one slot only
      else
        evt[i].kind <= evt_none;
    end
  end

endmodule

//--- rtl/tcp_conn_fsm.sv
`include "tcp_defs.svh"

module tcp_conn_fsm (
  input  logic                  clk,
  input  logic                  rst_rec,
  input  tcp_pkg::conn_ctl_t    ctl,
  input  tcp_pkg::rx_evt_t      evt,
  output tcp_pkg::conn_key_t    key,
  output tcp_pkg::conn_status_e status,
  output logic                  tx_req,
  output tcp_pkg::tcp_seg_t     tx_seg,
  input  logic                  tx_gnt
);
  import tcp_pkg::*;

  localparam int TMR_W = $clog2(`CONN_TIMEOUT + 1);
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(`CONN_TIMEOUT - 1);

  // urg ack psh rst syn fin
  localparam tcp_flags_t FLG_SYN     = 6'b000010;
  localparam tcp_flags_t FLG_SYN_ACK = 6'b010010;
  localparam tcp_flags_t FLG_ACK     = 6'b010000;
  localparam tcp_flags_t FLG_FIN_ACK = 6'b010001;
  localparam tcp_flags_t FLG_RST_ACK = 6'b010100;

  typedef enum logic [1:0] {
    close_none,
    close_active,
    close_passive,
    close_reset
  } close_e;

  conn_state_e state;
  close_e      close;

  // control block
  port_t loc_port;
  port_t rem_port;
  seq_t  loc_seq;
  seq_t  loc_ack;
  seq_t  rem_seq;
  seq_t  rem_ack;

  logic             passive;   // opened by listen
  logic             ack_rec;   // peer acked our fin
  logic             wait_drop; // closed, waiting for user to drop its request
  logic [TMR_W-1:0] tmr;
  logic             tmr_run;
  logic             usr_dcn;
  seq_t             ack_dif;

  function automatic tcp_seg_t mk_seg(input port_t sp, input port_t dp,
                                      input tcp_flags_t flg, input seq_t seq,
                                      input seq_t ack);
    tcp_seg_t s;
    s.src_port = sp;
    s.dst_port = dp;
    s.seq      = seq;
    s.ack      = ack;
    s.flags    = flg;
    return s;
  endfunction

  always_comb begin
    case (state)
      st_closed       : status = tcp_closed;
      st_listen       : status = tcp_listening;
      st_syn_sent,
      st_ack_sent,
      st_syn_ack_sent : status = tcp_connecting;
      st_established  : status = tcp_connected;
      default         : status = tcp_disconnecting;
    endcase
  end

  assign key.loc_port = loc_port;
  assign key.rem_port = rem_port;
  assign key.bound    = (state != st_closed) && (state != st_listen);
  assign key.open     = (status == tcp_listening) || (status == tcp_connecting);

  assign tmr_run = (status == tcp_connecting) || (status == tcp_disconnecting);
  assign usr_dcn = passive ? !ctl.listen : !ctl.connect;
  assign ack_dif = evt.ack - rem_ack; // msb set means behind

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      state     <= st_closed;
      close     <= close_none;
      tx_req    <= 1'b0;
      passive   <= 1'b0;
      ack_rec   <= 1'b0;
      wait_drop <= 1'b0;
      tmr       <= '0;
    end else begin
      if (tx_gnt) tx_req <= 1'b0; // request is held until granted
      if (tmr_run) tmr <= tmr + 1'b1;
      else tmr <= '0;
      case (state)
        st_closed : begin
          loc_port <= ctl.loc_port;
          rem_port <= ctl.rem_port;
          loc_seq  <= ctl.isn;
          loc_ack  <= '0;
          if (wait_drop) begin
            if (!ctl.listen && !ctl.connect) wait_drop <= 1'b0;
          end else if (ctl.listen) begin
            passive <= 1'b1;
            state   <= st_listen;
          end else if (ctl.connect) begin
            passive <= 1'b0;
            tx_req  <= 1'b1;
            tx_seg  <= mk_seg(ctl.loc_port, ctl.rem_port, FLG_SYN, ctl.isn, '0);
            state   <= st_syn_sent;
          end
        end
        //////////////////////////////
        // active open
        st_syn_sent : begin
          if (evt.kind == evt_syn_ack) begin
            rem_seq <= evt.seq + 1'b1;
            rem_ack <= evt.ack;
            loc_ack <= evt.seq + 1'b1;
            loc_seq <= loc_seq + 1'b1;
            tx_req  <= 1'b1;
            tx_seg  <= mk_seg(loc_port, rem_port, FLG_ACK, loc_seq + 1'b1, evt.seq + 1'b1);
            state   <= st_ack_sent;
          end
        end
        st_ack_sent : if (tx_gnt) state <= st_established;
        //////////////////////////////
        // passive open
        st_listen : begin
          if (!ctl.listen) begin
            state <= st_closed;
          end else if (evt.kind == evt_syn) begin
            rem_seq <= evt.seq + 1'b1; // ack must carry this seq
            loc_ack <= evt.seq + 1'b1;
            loc_seq <= ctl.isn;
            tx_req  <= 1'b1;
            tx_seg  <= mk_seg(loc_port, rem_port, FLG_SYN_ACK, ctl.isn, evt.seq + 1'b1);
            state   <= st_syn_ack_sent;
          end
        end
        st_syn_ack_sent : begin
          if (evt.kind == evt_ack && evt.seq == rem_seq) begin
            loc_seq <= loc_seq + 1'b1;
            rem_ack <= evt.ack;
            state   <= st_established;
          end
        end
        //////////////////////////////
        // established
        st_established : begin
          if (evt.kind != evt_none && !ack_dif[`SEQ_W-1]) rem_ack <= evt.ack;
          if (usr_dcn) close <= close_active;
          else if (evt.kind == evt_fin) close <= close_passive;
          else if (evt.kind == evt_rst) close <= close_reset;
          if (usr_dcn || evt.kind == evt_fin || evt.kind == evt_rst) state <= st_flush;
        end
        st_flush : begin
          loc_seq <= rem_ack; // drop anything not acked by the peer
          ack_rec <= 1'b0;
          tx_req  <= 1'b1;
          case (close)
            close_active : begin
              tx_seg <= mk_seg(loc_port, rem_port, FLG_FIN_ACK, rem_ack, loc_ack);
              state  <= st_fin_wait;
            end
            close_passive : begin
              loc_ack <= loc_ack + 1'b1;
              tx_seg  <= mk_seg(loc_port, rem_port, FLG_ACK, rem_ack, loc_ack + 1'b1);
              state   <= st_close_ack;
            end
            close_reset : begin
              tx_seg <= mk_seg(loc_port, rem_port, FLG_RST_ACK, rem_ack, loc_ack);
              state  <= st_last_ack;
            end
            default : begin
              tx_req <= 1'b0;
              state  <= st_closed;
            end
          endcase
        end
        //////////////////////////////
        // closing
        st_fin_wait : begin // ack first, then the peer's fin
          if (evt.kind == evt_ack) ack_rec <= 1'b1;
          if (evt.kind == evt_fin && ack_rec) begin
            loc_ack <= loc_ack + 1'b1;
            tx_req  <= 1'b1;
            tx_seg  <= mk_seg(loc_port, rem_port, FLG_ACK, loc_seq, loc_ack + 1'b1);
            state   <= st_last_ack;
          end
        end
        st_close_ack : if (tx_gnt) state <= st_send_fin;
        st_send_fin : begin
          tx_req <= 1'b1;
          tx_seg <= mk_seg(loc_port, rem_port, FLG_FIN_ACK, loc_seq, loc_ack);
          state  <= st_last_wait;
        end
        st_last_wait : begin
          if (evt.kind == evt_ack) begin
            tx_req    <= 1'b0;
            wait_drop <= 1'b1;
            state     <= st_closed;
          end
        end
        st_last_ack : begin
          if (tx_gnt) begin
            wait_drop <= 1'b1;
            state     <= st_closed;
          end
        end
        default : state <= st_closed;
      endcase
      // connect or disconnect ran too long
      if (tmr_run && tmr == TMR_LAST) begin
        tx_req    <= 1'b0;
        wait_drop <= 1'b1;
        state     <= st_closed;
      end
    end
  end

endmodule

//--- rtl/tcp_tx_arb.sv
`include "tcp_defs.svh"

module tcp_tx_arb (
  input  logic              clk,
  input  logic              rst_rec,
  input  logic              tx_req [`CONN_NUM],
  input  tcp_pkg::tcp_seg_t seg_in [`CONN_NUM],
  output logic              tx_gnt [`CONN_NUM],
  output logic              tx_val,
  output tcp_pkg::tcp_seg_t tx_seg,
  output tcp_pkg::slot_t    tx_slot
);
  import tcp_pkg::*;

  slot_t ptr;      // last slot granted
  slot_t sel;
  logic  sel_val;
  logic  gnt_any;

  // search starts one past the last grant
  always_comb begin
    int idx;
    sel_val = 1'b0;
    sel     = ptr;
    for (int k = `CONN_NUM; k >= 1; k--) begin
      idx = (int'(ptr) + k) % `CONN_NUM;
      if (tx_req[idx]) begin
        sel_val = 1'b1;
        sel     = slot_t'(idx);
      end
    end
  end

  // no grant while a segment is going out, keeps tx_val a strobe
  assign gnt_any = sel_val && !tx_val;

  always_comb begin
    for (int i = 0; i < `CONN_NUM; i++)
      tx_gnt[i] = gnt_any && (sel == slot_t'(i));
  end

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      tx_val <= 1'b0;
      ptr    <= slot_t'(`CONN_NUM - 1); // slot 0 goes first
    end else begin
      tx_val <= gnt_any;
      if (gnt_any) ptr <= sel;
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_any) begin
      tx_seg  <= seg_in[sel];
      tx_slot <= sel;
    end
  end

endmodule

//--- rtl/tcp_conn_top.sv
`include "tcp_defs.svh"

module tcp_conn_top (
  input  logic                  clk,
  input  logic                  rst_rec,
  input  logic                  rx_val,
  input  tcp_pkg::tcp_seg_t     rx_seg,
  input  tcp_pkg::conn_ctl_t    ctl    [`CONN_NUM],
  output logic                  tx_val,
  output tcp_pkg::tcp_seg_t     tx_seg,
  output tcp_pkg::slot_t        tx_slot,
  output tcp_pkg::conn_status_e status [`CONN_NUM]
);
  import tcp_pkg::*;

  conn_key_t keys   [`CONN_NUM];
  rx_evt_t   evt    [`CONN_NUM];
  logic      tx_req [`CONN_NUM];
  logic      tx_gnt [`CONN_NUM];
  tcp_seg_t  seg    [`CONN_NUM]; // per slot tx segment

  tcp_seg_dispatch i_dispatch (
    .clk     (clk),
    .rst_rec (rst_rec),
    .rx_val  (rx_val),
    .rx_seg  (rx_seg),
    .keys    (keys),
    .evt     (evt)
  );

  //////////////////////////////
  // connection slots
  for (genvar g = 0; g < `CONN_NUM; g++) begin : g_slot
    tcp_conn_fsm i_conn (
      .clk     (clk),
      .rst_rec (rst_rec),
      .ctl     (ctl[g]),
      .evt     (evt[g]),
      .key     (keys[g]),
      .status  (status[g]),
      .tx_req  (tx_req[g]),
      .tx_seg  (seg[g]),
      .tx_gnt  (tx_gnt[g])
    );
  end

  tcp_tx_arb i_arb (
    .clk     (clk),
    .rst_rec (rst_rec),
    .tx_req  (tx_req),
    .seg_in  (seg),
    .tx_gnt  (tx_gnt),
    .tx_val  (tx_val),
    .tx_seg  (tx_seg),
    .tx_slot (tx_slot)
  );

endmodule

//--- bench/tcp_conn_checker.sv
`include "tcp_defs.svh"

module tcp_conn_checker (
  input logic             clk,
  input logic             rst_rec,
  input logic             tx_val,
  input logic             tx_gnt [`CONN_NUM],
  input tcp_pkg::rx_evt_t evt    [`CONN_NUM]
);
  timeunit 1ns;
  timeprecision 100ps;

  import tcp_pkg::*;

  int gnt_cnt;
  int evt_cnt;

  always_comb begin
    gnt_cnt = 0;
    evt_cnt = 0;
    for (int i = 0; i < `CONN_NUM; i++) begin
      if (tx_gnt[i]) gnt_cnt = gnt_cnt + 1;
      if (evt[i].kind != evt_none) evt_cnt = evt_cnt + 1;
    end
  end

  //////////////////////////////
  // output stream
  a_tx_strobe : assert property (@(posedge clk) disable iff (rst_rec) tx_val |=> !tx_val)
    else $error("tx_val high for two cycles in a row");

  a_tx_reset : assert property (@(posedge clk) rst_rec |=> !tx_val)
    else $error("tx_val high during reset");

  // arbiter and dispatcher are one-hot at most
  a_one_gnt : assert property (@(posedge clk) disable iff (rst_rec) gnt_cnt <= 1)
    else $error("more than one tx_gnt at once");

  a_one_evt : assert property (@(posedge clk) disable iff (rst_rec) evt_cnt <= 1)
    else $error("more than one slot event in one cycle");

endmodule

bind tcp_conn_top tcp_conn_checker i_checker (
  .clk     (clk),
  .rst_rec (rst_rec),
  .tx_val  (tx_val),
  .tx_gnt  (tx_gnt),
  .evt     (evt)
);

//--- bench/tcp_conn_tb.sv
`include "tcp_defs.svh"

module tcp_conn_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import tcp_pkg::*;

  localparam int STS_WAIT = `CONN_TIMEOUT + 4; // cycles a status may take to settle

  logic         clk;
  logic         rst_rec;
  logic         rx_val;
  tcp_seg_t     rx_seg;
  conn_ctl_t    ctl    [`CONN_NUM];
  logic         tx_val;
  tcp_seg_t     tx_seg;
  slot_t        tx_slot;
  conn_status_e status [`CONN_NUM];

  tcp_seg_t tx_q [$];   // segments seen on the output
  slot_t    slot_q [$];
  int       fd;
  int       cycles = 0;
  int       cycle_limit = 0;

  tcp_conn_top i_dut (
    .clk     (clk),
    .rst_rec (rst_rec),
    .rx_val  (rx_val),
    .rx_seg  (rx_seg),
    .ctl     (ctl),
    .tx_val  (tx_val),
    .tx_seg  (tx_seg),
    .tx_slot (tx_slot),
    .status  (status)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("TESTBENCH FAILED");
    $display("%s", msg);
    $fatal(1);
  endtask

  //////////////////////////////
  // compare tasks
  task automatic check_seg(input string name, input tcp_seg_t exp, input tcp_seg_t act);
    if (act !== exp)
      stop_run($sformatf("error in %s: expected segment %h, actual %h", name, exp, act));
  endtask

  task automatic check_slot(input string name, input slot_t exp, input slot_t act);
    if (act !== exp)
      stop_run($sformatf("error in %s: expected slot %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_status(input string name, input conn_status_e exp,
                              input conn_status_e act);
    if (act !== exp)
      stop_run($sformatf("error in %s: expected status %s, actual %s", name,
                         exp.name(), act.name()));
  endtask

  // output monitor, samples mid-cycle
  always @(negedge clk) begin
    if (tx_val) begin
      tx_q.push_back(tx_seg);
      slot_q.push_back(tx_slot);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
      stop_run($sformatf("simulation timed out after %0d cycles", cycles));
  end

  //////////////////////////////
  // steps
  task automatic apply_ctl(input slot_t s, input conn_ctl_t c);
    ctl[s] <= c;
    @(posedge clk);
  endtask

  // returns once the slot has acted on the event
  task automatic inject_seg(input tcp_seg_t s);
    rx_seg <= s;
    rx_val <= 1'b1;
    @(posedge clk);
    rx_val <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic expect_seg(input string name, input slot_t s, input tcp_seg_t e);
    slot_t    act_slot;
    tcp_seg_t act_seg;
    while (tx_q.size() == 0) @(posedge clk);
    act_slot = slot_q.pop_front();
    act_seg  = tx_q.pop_front();
    check_slot(name, s, act_slot);
    check_seg(name, e, act_seg);
  endtask

  task automatic wait_status(input string name, input slot_t s, input conn_status_e e);
    int n;
    n = 0;
    @(negedge clk);
    while (status[s] != e && n < STS_WAIT) begin
      @(negedge clk);
      n++;
    end
    check_status(name, e, status[s]);
    @(posedge clk);
  endtask

  task automatic read_seg(output tcp_seg_t s);
    logic [15:0] sp;
    logic [15:0] dp;
    logic [5:0]  flg;
    logic [31:0] sq;
    logic [31:0] ak;
    int          r;
    r = $fscanf(fd, "%h %h %h %h %h", sp, dp, flg, sq, ak);
    if (r != 5) stop_run("case file holds a segment line with missing fields");
    s.src_port = sp;
    s.dst_port = dp;
    s.seq      = sq;
    s.ack      = ak;
    s.flags    = flg;
  endtask

  initial begin
    string       kind;
    string       name;
    string       line;
    int          r;
    int          slot_n;
    int          lis;
    int          con;
    int          sts_n;
    int          n_lines;
    logic [15:0] lp;
    logic [15:0] rp;
    logic [31:0] isn;
    conn_ctl_t   c;
    tcp_seg_t    s;
    rst_rec = 1'b1;
    rx_val  = 1'b0;
    rx_seg  = '0;
    for (int i = 0; i < `CONN_NUM; i++) ctl[i] = '0;
    fd = $fopen("bench/tcp_cases.txt", "r");
    if (fd == 0) stop_run("cannot open the case file");
    n_lines = 0;
    while ($fgets(line, fd) != 0) n_lines++;
    $fclose(fd);
    cycle_limit = (n_lines + 2) * `CONN_TIMEOUT;
    fd = $fopen("bench/tcp_cases.txt", "r");
    repeat (10) @(posedge clk);
    rst_rec <= 1'b0;
    @(posedge clk);
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind.substr(0, 0) == "#") begin
        r = $fgets(line, fd); // skip the rest of a comment
      end else if (kind == "ctl") begin
        r = $fscanf(fd, "%s %d %d %d %h %h %h", name, slot_n, lis, con, lp, rp, isn);
        c.listen   = (lis != 0);
        c.connect  = (con != 0);
        c.loc_port = lp;
        c.rem_port = rp;
        c.isn      = isn;
        apply_ctl(slot_t'(slot_n), c);
      end else if (kind == "seg") begin
        r = $fscanf(fd, "%s", name);
        read_seg(s);
        inject_seg(s);
      end else if (kind == "exp") begin
        r = $fscanf(fd, "%s %d", name, slot_n);
        read_seg(s);
        expect_seg(name, slot_t'(slot_n), s);
      end else if (kind == "sts") begin
        r = $fscanf(fd, "%s %d %d", name, slot_n, sts_n);
        wait_status(name, slot_t'(slot_n), conn_status_e'(sts_n));
      end else begin
        stop_run($sformatf("unknown entry %s in the case file", kind));
      end
    end
    $fclose(fd);
    repeat (4) @(posedge clk);
    if (tx_q.size() != 0) begin
      stop_run($sformatf("%0d transmitted segments were never expected", tx_q.size()));
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

//--- bench/tcp_cases.txt
# ctl name slot listen connect loc_port rem_port isn | sts name slot status (0..4)
# seg name src dst flags seq ack | exp name slot src dst flags seq ack (hex, ack=10 rst=04 syn=02 fin=01)
ctl a_open        0 0 1 1000 5000 00000100
exp a_syn         0 1000 5000 02 00000100 00000000
seg a_syn_ack     5000 1000 12 00007000 00000101
exp a_ack         0 1000 5000 10 00000101 00007001
sts a_connected   0 3
ctl p_listen      1 1 0 2000 6000 00000200
seg p_syn         6000 2000 02 00009000 00000000
exp p_syn_ack     1 2000 6000 12 00000200 00009001
seg p_bad_ack     6000 2000 10 00009005 00000201
sts p_still_conn  1 2
seg p_ack         6000 2000 10 00009001 00000201
sts p_connected   1 3
sts p_slot0_kept  0 3
seg c_ack_fwd     5000 1000 10 00007001 00000500
seg c_ack_old     5000 1000 10 00007001 00000300
ctl c_drop        0 0 0 1000 5000 00000100
exp c_fin         0 1000 5000 11 00000500 00007001
seg c_peer_ack    5000 1000 10 00007001 00000501
seg c_peer_fin    5000 1000 11 00007001 00000501
exp c_last_ack    0 1000 5000 10 00000500 00007002
sts c_closed      0 0
seg f_peer_fin    6000 2000 11 00009001 00000201
exp f_ack         1 2000 6000 10 00000201 00009002
exp f_fin         1 2000 6000 11 00000201 00009002
seg f_peer_ack    6000 2000 10 00009002 00000202
sts f_closed      1 0
ctl r_open        0 0 1 1000 5000 00000400
exp r_syn         0 1000 5000 02 00000400 00000000
seg r_syn_ack     5000 1000 12 0000a000 00000401
exp r_ack         0 1000 5000 10 00000401 0000a001
seg r_rst         5000 1000 04 0000a001 00000401
exp r_rst_ack     0 1000 5000 14 00000401 0000a001
sts r_closed      0 0
ctl t_drop        1 0 0 2000 7000 00000800
ctl t_open        1 0 1 2000 7000 00000800
exp t_syn         1 2000 7000 02 00000800 00000000
sts t_closed      1 0

//--- vlog.f
+incdir+rtl
rtl/tcp_pkg.sv
rtl/tcp_seg_dispatch.sv
rtl/tcp_conn_fsm.sv
rtl/tcp_tx_arb.sv
rtl/tcp_conn_top.sv
bench/tcp_conn_checker.sv
bench/tcp_conn_tb.sv
